// File: design/cdi_bridge_pkg.sv
package cdi_bridge_pkg;

    // ======================================================================
    // Widths with a meaning of their own
    // ======================================================================
    typedef logic [15:0] host_word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [24:0] ioctl_addr_t;
    typedef logic [15:0] ioctl_index_t;
    typedef logic [24:0] sdram_addr_t;
    typedef logic [12:0] nvram_addr_t;
    typedef logic [12:0] worm_addr_t;
    typedef logic [7:0]  buff_addr_t;

    // Upper SDRAM address bits of the ROM images
    localparam logic [4:0] ROM_SDRAM_PREFIX = 5'b00100;

    // Download target, taken from index bits 7:6
    localparam logic [1:0] IDX_MAIN_ROM  = 2'b00;
    localparam logic [1:0] IDX_WORM      = 2'b01;
    localparam logic [1:0] IDX_VMPEG_ROM = 2'b10;

    // ======================================================================
    // State machines
    // ======================================================================
    typedef enum logic [1:0] {
        ROM_DOWNLOAD,
        REFRESH,
        SDRAM_IDLE
    } sdram_owner_e;

    typedef enum logic [3:0] {
        IDLE,
        WAIT_FOR_ACK,
        BACKUP0,
        BACKUP1,
        BACKUP2,
        BACKUP3,
        RESTORE0,
        RESTORE1,
        RESTORE2
    } nvram_state_e;

    // ======================================================================
    // Bundles
    // ======================================================================
    typedef struct packed {
        logic         wr;
        ioctl_addr_t  addr;
        host_word_t   dout;
        ioctl_index_t index;
    } ioctl_wr_s;

    typedef struct packed {
        sdram_addr_t addr;
        host_word_t  din;
        logic        wr;
        logic        rd;
        logic        refresh;
    } sdram_prep_s;

    typedef struct packed {
        worm_addr_t adr;
        byte_t      data;
        logic       wr;
    } worm_wr_s;

    typedef struct packed {
        buff_addr_t addr;
        host_word_t dout;
        logic       wr;
    } sd_buff_s;

    typedef struct packed {
        nvram_addr_t adr;
        byte_t       restore_data;
        logic        restore_write;
        logic        allow_cpu_access;
    } nvram_port_s;

endpackage

// File: design/rom_sdram_loader.sv
`timescale 1ns/1ns

module rom_sdram_loader
    import cdi_bridge_pkg::*;
(
    input  logic        clk_sys,
    input  logic        cditop_reset,
    input  ioctl_wr_s   ioctl,
    input  logic        ioctl_download,
    input  logic        sdram_busy,
    output sdram_prep_s sdram_prep,
    output logic        download_overflow
);

    logic         rom_wr;
    logic         wr_latch;
    logic         wr_issued;
    logic         busy_q;
    sdram_owner_e owner;
    sdram_owner_e owner_q;
    sdram_owner_e owner_next;

    // Main CPU ROM and MPEG cartridge ROM both land in SDRAM
    assign rom_wr = ioctl.wr && (ioctl.index[7:6] == IDX_MAIN_ROM ||
                                 ioctl.index[7:6] == IDX_VMPEG_ROM);

    // A pending word wins, refresh fills the gaps of a download
    always_comb begin
        owner_next = SDRAM_IDLE;
        if (wr_latch) begin
            owner_next = ROM_DOWNLOAD;
        end else if (ioctl_download) begin
            owner_next = REFRESH;
        end
        owner = sdram_busy ? owner_q : owner_next;
    end

    always_comb begin
        // Host words are little endian, the 68k wants big endian
        sdram_prep.din     = {ioctl.dout[7:0], ioctl.dout[15:8]};
        sdram_prep.addr    = {ROM_SDRAM_PREFIX, ioctl.index[7], ioctl.addr[18:1], 1'b0};
        sdram_prep.wr      = (owner == ROM_DOWNLOAD) && !wr_issued;
        sdram_prep.rd      = (owner == REFRESH);
        sdram_prep.refresh = (owner == REFRESH);
        if (sdram_busy) begin
            sdram_prep.wr      = 1'b0;
            sdram_prep.rd      = 1'b0;
            sdram_prep.refresh = 1'b0;
        end
    end

    // The controller takes the write and answers with busy from the next cycle
    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            wr_latch          <= 1'b0;
            wr_issued         <= 1'b0;
            busy_q            <= 1'b0;
            owner_q           <= SDRAM_IDLE;
            download_overflow <= 1'b0;
        end else begin
            busy_q  <= sdram_busy;
            owner_q <= owner;
            if (wr_latch && ioctl.wr) download_overflow <= 1'b1;
            if (rom_wr) wr_latch <= 1'b1;
            if (sdram_prep.wr) wr_issued <= 1'b1;
            // Word is done once busy falls after our own write
            if (owner == ROM_DOWNLOAD && wr_issued && busy_q && !sdram_busy) begin
                wr_latch  <= 1'b0;
                wr_issued <= 1'b0;
            end
        end
    end

    // Pending word only completes when busy answers the write
    a_write_answered: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        sdram_prep.wr |=> sdram_busy)
        else $error("sdram_prep write not answered with sdram_busy");

endmodule

// File: design/worm_byte_writer.sv
`timescale 1ns/1ns

module worm_byte_writer
    import cdi_bridge_pkg::*;
(
    input  logic      clk_sys,
    input  logic      cditop_reset,
    input  ioctl_wr_s ioctl,
    output worm_wr_s  worm
);

    logic       worm_wr;
    logic       worm_wr_q;
    logic       wr_r;
    worm_addr_t adr_r;
    byte_t      data_r;
    byte_t      high_byte;

    assign worm_wr = ioctl.wr && (ioctl.index[7:6] == IDX_WORM);

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            worm_wr_q <= 1'b0;
            wr_r      <= 1'b0;
        end else begin
            worm_wr_q <= worm_wr;
            wr_r      <= worm_wr || worm_wr_q;
        end
    end

    // Low byte goes first, the high byte follows at the odd address
    always_ff @(posedge clk_sys) begin
        if (worm_wr) begin
            adr_r     <= ioctl.addr[12:0];
            data_r    <= ioctl.dout[7:0];
            high_byte <= ioctl.dout[15:8];
        end else begin
            data_r   <= high_byte;
            adr_r[0] <= 1'b1;
        end
    end

    assign worm = '{adr: adr_r, data: data_r, wr: wr_r};

    a_second_byte: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        worm_wr_q |=> (worm.wr && worm.adr[0]))
        else $error("WORM low byte not followed by odd address write");

endmodule

// File: design/nvram_sync_fsm.sv
`timescale 1ns/1ns

module nvram_sync_fsm
    import cdi_bridge_pkg::*;
(
    input  logic         clk_sys,
    input  logic         cditop_reset,
    input  logic         nvram_media_change,
    input  logic         img_size_nonzero,
    input  logic         osd_status,
    input  logic         nvram_cpu_changed,
    input  logic         nvram_hps_ack,
    input  logic         buff_step,
    input  logic         sd_buff_wr,
    output nvram_state_e state,
    output logic         nvram_hps_rd,
    output logic         nvram_hps_wr,
    output logic         led_user,
    output logic         allow_cpu_access
);

    logic img_mount;
    logic img_mounted;
    logic backup_pending;
    logic osd_status_q;
    logic menu_open;

    assign img_mount = nvram_media_change && img_size_nonzero;
    assign menu_open = osd_status && !osd_status_q;

    // LED tells the user a backup is still owed
    assign led_user = backup_pending;

    // CPU keeps away from NvRAM during a whole transfer
    assign allow_cpu_access = (state == IDLE);

    // ======================================================================
    // Block transfer sequencing
    // ======================================================================
    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            state          <= IDLE;
            nvram_hps_rd   <= 1'b0;
            nvram_hps_wr   <= 1'b0;
            img_mounted    <= 1'b0;
            backup_pending <= 1'b0;
            osd_status_q   <= 1'b0;
        end else begin
            osd_status_q <= osd_status;

            if (nvram_media_change) img_mounted <= img_size_nonzero;
            if (nvram_cpu_changed && img_mounted) backup_pending <= 1'b1;

            if (nvram_hps_ack) begin
                nvram_hps_rd <= 1'b0;
                nvram_hps_wr <= 1'b0;
            end

            case (state)
                IDLE: begin
                    if (img_mount) begin
                        // Fresh image, pull it into NvRAM
                        nvram_hps_rd <= 1'b1;
                        state        <= WAIT_FOR_ACK;
                    end else if (backup_pending && menu_open) begin
                        backup_pending <= 1'b0;
                        nvram_hps_wr   <= 1'b1;
                        state          <= WAIT_FOR_ACK;
                    end
                end
                WAIT_FOR_ACK: begin
                    if (nvram_hps_ack) begin
                        if (nvram_hps_rd) state <= RESTORE0;
                        if (nvram_hps_wr) state <= BACKUP0;
                    end
                end
                // First read address goes out, data follows a cycle later
                BACKUP0: state <= BACKUP1;
                BACKUP1: state <= BACKUP2;
                BACKUP2: state <= BACKUP3;
                BACKUP3: begin
                    if (buff_step) state <= BACKUP1;
                    if (!nvram_hps_ack) state <= IDLE;
                end
                RESTORE0: begin
                    if (sd_buff_wr) state <= RESTORE1;
                    if (!nvram_hps_ack) state <= IDLE;
                end
                RESTORE1: state <= RESTORE2;
                RESTORE2: state <= RESTORE0;
                default: state <= IDLE;
            endcase
        end
    end

    a_one_request: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        !(nvram_hps_rd && nvram_hps_wr))
        else $error("NvRAM read and write requested together");

endmodule

// File: design/nvram_xfer_counter.sv
`timescale 1ns/1ns

module nvram_xfer_counter
    import cdi_bridge_pkg::*;
(
    input  logic         clk_sys,
    input  logic         cditop_reset,
    input  nvram_state_e state,
    input  buff_addr_t   buff_addr,
    output nvram_addr_t  adr,
    output logic         buff_step
);

    logic buff_lsb_q;
    logic adr_inc;

    // Host moved on to the next buffer word
    assign buff_step = (buff_addr[0] != buff_lsb_q);

    always_comb begin
        case (state)
            BACKUP0, BACKUP1, RESTORE1, RESTORE2: adr_inc = 1'b1;
            BACKUP3: adr_inc = buff_step;
            default: adr_inc = 1'b0;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            adr        <= '0;
            buff_lsb_q <= 1'b0;
        end else begin
            buff_lsb_q <= buff_addr[0];
            // Every transfer starts at byte zero
            if (state == IDLE) begin
                adr <= '0;
            end else if (adr_inc) begin
                adr <= adr + 1'b1;
            end
        end
    end

endmodule

// File: design/nvram_word_buffer.sv
`timescale 1ns/1ns

module nvram_word_buffer
    import cdi_bridge_pkg::*;
(
    input  logic         clk_sys,
    input  nvram_state_e state,
    input  sd_buff_s     sd_buff,
    input  byte_t        backup_data,
    input  logic         adr_lsb,
    output host_word_t   hps_din,
    output byte_t        restore_data,
    output logic         restore_write
);

    host_word_t restore_word;

    always_ff @(posedge clk_sys) begin
        if (state == RESTORE0 && sd_buff.wr) restore_word <= sd_buff.dout;
        // Synchronous NvRAM read, low byte lands first
        if (state == BACKUP1) hps_din[7:0] <= backup_data;
        if (state == BACKUP2) hps_din[15:8] <= backup_data;
    end

    // Even address takes the low byte of the host word
    assign restore_data = adr_lsb ? restore_word[15:8] : restore_word[7:0];

    // One byte write in each of the two cycles after capture
    assign restore_write = (state == RESTORE1) || (state == RESTORE2);

endmodule

// File: design/cdi_host_bridge.sv
`timescale 1ns/1ns

module cdi_host_bridge
    import cdi_bridge_pkg::*;
(
    input  logic        clk_sys,
    input  logic        cditop_reset,

    // Boot ROM and WORM download
    input  ioctl_wr_s   ioctl,
    input  logic        ioctl_download,
    input  logic        sdram_busy,
    output sdram_prep_s sdram_prep,
    output logic        download_overflow,
    output worm_wr_s    worm,

    // NvRAM image block transfers
    input  logic        nvram_media_change,
    input  logic        img_size_nonzero,
    input  logic        osd_status,
    input  logic        nvram_cpu_changed,
    input  logic        nvram_hps_ack,
    input  sd_buff_s    sd_buff,
    input  byte_t       nvram_backup_data,
    output logic        nvram_hps_rd,
    output logic        nvram_hps_wr,
    output host_word_t  nvram_hps_din,
    output nvram_port_s nvram_port,
    output logic        led_user
);

    nvram_state_e nv_state;
    nvram_addr_t  nv_adr;
    logic         buff_step;
    byte_t        restore_data;
    logic         restore_write;
    logic         allow_cpu_access;

    // ======================================================================
    // Download path
    // ======================================================================
    rom_sdram_loader u_loader (
        .clk_sys           (clk_sys),
        .cditop_reset      (cditop_reset),
        .ioctl             (ioctl),
        .ioctl_download    (ioctl_download),
        .sdram_busy        (sdram_busy),
        .sdram_prep        (sdram_prep),
        .download_overflow (download_overflow)
    );

    worm_byte_writer u_worm (
        .clk_sys      (clk_sys),
        .cditop_reset (cditop_reset),
        .ioctl        (ioctl),
        .worm         (worm)
    );

    // ======================================================================
    // NvRAM path
    // ======================================================================
    nvram_sync_fsm u_fsm (
        .clk_sys            (clk_sys),
        .cditop_reset       (cditop_reset),
        .nvram_media_change (nvram_media_change),
        .img_size_nonzero   (img_size_nonzero),
        .osd_status         (osd_status),
        .nvram_cpu_changed  (nvram_cpu_changed),
        .nvram_hps_ack      (nvram_hps_ack),
        .buff_step          (buff_step),
        .sd_buff_wr         (sd_buff.wr),
        .state              (nv_state),
        .nvram_hps_rd       (nvram_hps_rd),
        .nvram_hps_wr       (nvram_hps_wr),
        .led_user           (led_user),
        .allow_cpu_access   (allow_cpu_access)
    );

    nvram_xfer_counter u_counter (
        .clk_sys      (clk_sys),
        .cditop_reset (cditop_reset),
        .state        (nv_state),
        .buff_addr    (sd_buff.addr),
        .adr          (nv_adr),
        .buff_step    (buff_step)
    );

    nvram_word_buffer u_buffer (
        .clk_sys       (clk_sys),
        .state         (nv_state),
        .sd_buff       (sd_buff),
        .backup_data   (nvram_backup_data),
        .adr_lsb       (nv_adr[0]),
        .hps_din       (nvram_hps_din),
        .restore_data  (restore_data),
        .restore_write (restore_write)
    );

    assign nvram_port = '{
        adr:              nv_adr,
        restore_data:     restore_data,
        restore_write:    restore_write,
        allow_cpu_access: allow_cpu_access
    };

endmodule

// File: tb/tb_cdi_host_bridge.sv
`timescale 1ns/1ns

module tb_cdi_host_bridge
    import cdi_bridge_pkg::*;
();

    localparam logic [31:0] SEED = 32'h729a7ad6;
    localparam int WORM_WORDS      = 6;
    localparam int ROM_WORDS       = 8;
    localparam int NV_WORDS        = 6;
    localparam int ROM_WORD_CYCLES = 40;
    // Reset, WORM, ROM with overflow, restore and backup, then a margin
    localparam int RUN_CYCLES = 8 + WORM_WORDS * 3 + (ROM_WORDS + 2) * ROM_WORD_CYCLES
                              + NV_WORDS * 9 + 200;

    logic        clk_sys = 1'b0;
    logic        cditop_reset;
    ioctl_wr_s   ioctl;
    logic        ioctl_download;
    logic        sdram_busy;
    sdram_prep_s sdram_prep;
    logic        download_overflow;
    worm_wr_s    worm;
    logic        nvram_media_change;
    logic        img_size_nonzero;
    logic        osd_status;
    logic        nvram_cpu_changed;
    logic        nvram_hps_ack;
    sd_buff_s    sd_buff;
    byte_t       nvram_backup_data;
    logic        nvram_hps_rd;
    logic        nvram_hps_wr;
    host_word_t  nvram_hps_din;
    nvram_port_s nvram_port;
    logic        led_user;

    logic [31:0] rng_state;
    sdram_addr_t exp_addr;
    host_word_t  exp_din;
    nvram_addr_t last_nv_adr;
    int          sdram_writes;
    int          errors;
    int          errors_at_start;
    int          tests_passed;
    int          tests_failed;

    cdi_host_bridge dut (.*);

    always #50 clk_sys = ~clk_sys;

    // Writes the SDRAM takes at each rising edge
    always @(posedge clk_sys) begin
        if (sdram_prep.wr) sdram_writes++;
    end

    // ======================================================================
    // Random numbers and the NvRAM model
    // ======================================================================
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = lcg_step(rng_state);
        return rng_state;
    endfunction

    // NvRAM content is a hash of the byte address
    function automatic byte_t nvram_byte(input nvram_addr_t a);
        logic [31:0] h;
        h = lcg_step(SEED ^ {19'h0, a});
        return h[23:16];
    endfunction

    task automatic next_cycle();
        @(negedge clk_sys);
        // Synchronous read of the address held during the previous cycle
        nvram_backup_data = nvram_byte(last_nv_adr);
        last_nv_adr = nvram_port.adr;
    endtask

    // ======================================================================
    // Checks and reporting
    // ======================================================================
    task automatic check_hex(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (exp == got) else begin
            errors++;
            $display("** Error: %s expected %h, got %h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    task automatic finish_test(input string name);
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    task automatic check_quiet();
        check_hex("sdram_prep.wr", 0, 32'(sdram_prep.wr));
        check_hex("sdram_prep.rd", 0, 32'(sdram_prep.rd));
        check_hex("sdram_prep.refresh", 0, 32'(sdram_prep.refresh));
        check_hex("worm.wr", 0, 32'(worm.wr));
        check_hex("nvram_hps_rd", 0, 32'(nvram_hps_rd));
        check_hex("nvram_hps_wr", 0, 32'(nvram_hps_wr));
        check_hex("nvram_port.restore_write", 0, 32'(nvram_port.restore_write));
        check_hex("download_overflow", 0, 32'(download_overflow));
        check_hex("led_user", 0, 32'(led_user));
        check_hex("nvram_port.allow_cpu_access", 1, 32'(nvram_port.allow_cpu_access));
    endtask

    a_wr_not_busy: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        sdram_prep.wr |-> !sdram_busy)
        else begin
            errors++;
            $display("SDRAM write issued while sdram_busy was high at %0t", $time);
        end

    a_wr_mapping: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        sdram_prep.wr |-> (sdram_prep.addr == exp_addr && sdram_prep.din == exp_din))
        else begin
            errors++;
            $display("** Error: sdram_prep.addr expected %h, got %h", exp_addr, sdram_prep.addr);
            $display("** Error: sdram_prep.din expected %h, got %h", exp_din, sdram_prep.din);
        end

    a_refresh_in_download: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        sdram_prep.refresh |-> ioctl_download)
        else begin
            errors++;
            $display("Refresh requested outside a download at %0t", $time);
        end

    a_cpu_locked: assert property (@(posedge clk_sys) disable iff (cditop_reset)
        (nvram_hps_rd || nvram_hps_wr || nvram_port.restore_write)
            |-> !nvram_port.allow_cpu_access)
        else begin
            errors++;
            $display("CPU allowed into NvRAM during a transfer at %0t", $time);
        end

    // ======================================================================
    // Download stimulus
    // ======================================================================
    task automatic worm_word();
        logic [31:0] r;
        ioctl_addr_t a;
        r = rand32();
        a = 25'(rand32());
        ioctl = '{wr: 1'b1, addr: a, dout: r[15:0], index: {8'h00, IDX_WORM, 6'h00}};
        next_cycle();
        ioctl.wr = 1'b0;
        check_hex("worm.wr", 1, 32'(worm.wr));
        check_hex("worm.adr", 32'(a[12:0]), 32'(worm.adr));
        check_hex("worm.data", 32'(r[7:0]), 32'(worm.data));
        next_cycle();
        check_hex("worm.wr", 1, 32'(worm.wr));
        check_hex("worm.adr", 32'({a[12:1], 1'b1}), 32'(worm.adr));
        check_hex("worm.data", 32'(r[15:8]), 32'(worm.data));
        next_cycle();
        check_hex("worm.wr", 0, 32'(worm.wr));
    endtask

    task automatic present_rom_word(input logic idx7);
        logic [31:0] r;
        ioctl_addr_t a;
        r = rand32();
        a = 25'(rand32());
        ioctl = '{wr: 1'b1, addr: a, dout: r[15:0], index: {8'h00, idx7, 7'h00}};
        // Prefix, ROM select, word address; bytes swapped for the 68k
        exp_addr = {ROM_SDRAM_PREFIX, idx7, a[18:1], 1'b0};
        exp_din  = {r[7:0], r[15:8]};
    endtask

    // SDRAM controller model, busy for a random time after each write
    task automatic serve_sdram(input int busy_left);
        int   start;
        int   seen;
        int   n;
        logic done;
        start = sdram_writes;
        seen = sdram_writes;
        done = 1'b0;
        for (n = 0; n < ROM_WORD_CYCLES && !done; n++) begin
            next_cycle();
            ioctl.wr = 1'b0;
            if (sdram_writes != seen) begin
                // Write taken at the last rising edge, busy from this cycle on
                seen = sdram_writes;
                busy_left = int'(rand32() % 4);
                sdram_busy = 1'b1;
            end else if (busy_left > 0) begin
                sdram_busy = 1'b1;
                busy_left--;
            end else begin
                done = (seen != start) && !sdram_busy && sdram_prep.refresh;
                sdram_busy = 1'b0;
            end
        end
        if (!done) note_failure("ROM word never completed and refresh did not resume");
        check_hex("sdram_prep.wr count", 1, 32'(sdram_writes - start));
    endtask

    task automatic rom_word(input logic idx7);
        int pre_busy;
        pre_busy = int'(rand32() % 3);
        present_rom_word(idx7);
        sdram_busy = (pre_busy != 0);
        serve_sdram(pre_busy);
    endtask

    task automatic rom_test();
        logic [31:0] r;
        int          n;
        ioctl_download = 1'b1;
        next_cycle();
        check_hex("sdram_prep.refresh", 1, 32'(sdram_prep.refresh));
        for (n = 0; n < ROM_WORDS; n++) begin
            r = rand32();
            rom_word(r[31]);
        end
        check_hex("download_overflow", 0, 32'(download_overflow));
        // Second word lands while the first is stuck behind busy
        r = rand32();
        sdram_busy = 1'b1;
        present_rom_word(r[31]);
        next_cycle();
        ioctl.wr = 1'b1;
        next_cycle();
        ioctl.wr = 1'b0;
        next_cycle();
        check_hex("download_overflow", 1, 32'(download_overflow));
        serve_sdram(0);
        ioctl_download = 1'b0;
        next_cycle();
        check_hex("sdram_prep.rd", 0, 32'(sdram_prep.rd));
        check_hex("sdram_prep.refresh", 0, 32'(sdram_prep.refresh));
        check_hex("download_overflow", 1, 32'(download_overflow));
    endtask

    // ======================================================================
    // NvRAM stimulus
    // ======================================================================
    task automatic restore_test();
        logic [31:0] r;
        int          n;
        int          w;
        nvram_media_change = 1'b1;
        img_size_nonzero = 1'b1;
        next_cycle();
        nvram_media_change = 1'b0;
        for (n = 0; n < 8 && !nvram_hps_rd; n++) next_cycle();
        if (!nvram_hps_rd) note_failure("mount raised no nvram_hps_rd");
        nvram_hps_ack = 1'b1;
        for (n = 0; n < 8 && nvram_hps_rd; n++) next_cycle();
        if (nvram_hps_rd) note_failure("nvram_hps_rd stayed high after the ack");
        for (w = 0; w < NV_WORDS; w++) begin
            r = rand32();
            sd_buff = '{addr: 8'(w), dout: r[15:0], wr: 1'b1};
            next_cycle();
            sd_buff.wr = 1'b0;
            check_hex("nvram_port.restore_write", 1, 32'(nvram_port.restore_write));
            check_hex("nvram_port.adr", 2 * w, 32'(nvram_port.adr));
            check_hex("nvram_port.restore_data", 32'(r[7:0]), 32'(nvram_port.restore_data));
            next_cycle();
            check_hex("nvram_port.restore_write", 1, 32'(nvram_port.restore_write));
            check_hex("nvram_port.adr", 2 * w + 1, 32'(nvram_port.adr));
            check_hex("nvram_port.restore_data", 32'(r[15:8]), 32'(nvram_port.restore_data));
            next_cycle();
            check_hex("nvram_port.restore_write", 0, 32'(nvram_port.restore_write));
            check_hex("nvram_port.allow_cpu_access", 0, 32'(nvram_port.allow_cpu_access));
        end
        nvram_hps_ack = 1'b0;
        for (n = 0; n < 8 && !nvram_port.allow_cpu_access; n++) next_cycle();
        if (!nvram_port.allow_cpu_access) note_failure("CPU access not back after restore");
    endtask

    task automatic backup_test();
        int n;
        int w;
        sd_buff = '{addr: 8'h00, dout: 16'h0000, wr: 1'b0};
        nvram_cpu_changed = 1'b1;
        next_cycle();
        nvram_cpu_changed = 1'b0;
        check_hex("led_user", 1, 32'(led_user));
        osd_status = 1'b1;
        for (n = 0; n < 8 && !nvram_hps_wr; n++) next_cycle();
        if (!nvram_hps_wr) note_failure("menu opening raised no nvram_hps_wr");
        check_hex("led_user", 0, 32'(led_user));
        nvram_hps_ack = 1'b1;
        for (w = 0; w < NV_WORDS; w++) begin
            // Host moves to the next buffer word
            if (w > 0) sd_buff.addr = sd_buff.addr + 8'h01;
            repeat (5) next_cycle();
            check_hex("nvram_hps_din",
                      32'({nvram_byte(13'(2 * w + 1)), nvram_byte(13'(2 * w))}),
                      32'(nvram_hps_din));
        end
        nvram_hps_ack = 1'b0;
        osd_status = 1'b0;
        for (n = 0; n < 8 && !nvram_port.allow_cpu_access; n++) next_cycle();
        if (!nvram_port.allow_cpu_access) note_failure("CPU access not back after backup");
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        int n;
        rng_state = SEED;
        last_nv_adr = '0;
        sdram_writes = 0;
        errors = 0;
        errors_at_start = 0;
        tests_passed = 0;
        tests_failed = 0;
        cditop_reset = 1'b1;
        ioctl = '0;
        ioctl_download = 1'b0;
        sdram_busy = 1'b0;
        nvram_media_change = 1'b0;
        img_size_nonzero = 1'b0;
        osd_status = 1'b0;
        nvram_cpu_changed = 1'b0;
        nvram_hps_ack = 1'b0;
        sd_buff = '0;
        nvram_backup_data = '0;

        repeat (3) begin
            next_cycle();
            check_quiet();
        end
        cditop_reset = 1'b0;
        next_cycle();
        check_quiet();
        finish_test("reset_state");

        for (n = 0; n < WORM_WORDS; n++) worm_word();
        finish_test("worm_split");
        rom_test();
        finish_test("rom_download");
        restore_test();
        finish_test("nvram_restore");
        backup_test();
        finish_test("nvram_backup");

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * 100);
        $display("Timeout: run did not finish within %0d cycles", RUN_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: tb.f
design/cdi_bridge_pkg.sv
design/rom_sdram_loader.sv
design/worm_byte_writer.sv
design/nvram_sync_fsm.sv
design/nvram_xfer_counter.sv
design/nvram_word_buffer.sv
design/cdi_host_bridge.sv
tb/tb_cdi_host_bridge.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cdi_host_bridge \
    -f tb.f -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log \
    || echo "Build or simulation error"
grep -q "STATUS: PASS" sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
